// File: filelist.f
hw/cache_pkg.sv
hw/line_if.sv
hw/icache.sv
hw/dcache.sv
hw/line_arbiter.sv
hw/bmem_burst.sv
hw/cache_unit.sv
test/cache_unit_props.sv
test/tb_cache_unit.sv

// File: hw/bmem_burst.sv
module bmem_burst (
    input  logic             clk,
    input  logic             rst,
    line_if.server           line,
    output cache_pkg::addr_t o_bmem_addr,
    output logic             o_bmem_read,
    output logic             o_bmem_write,
    output cache_pkg::beat_t o_bmem_wdata,
    input  logic             i_bmem_ready,
    input  cache_pkg::beat_t i_bmem_rdata,
    input  logic             i_bmem_rvalid
);
    import cache_pkg::*;

    burst_state_t state;
    burst_state_t next;
    logic [1:0] cnt;
    logic last;
    // first three returned beats, newest on top
    logic [LINE_BITS-$bits(beat_t)-1:0] rbuf;

    assign last = (cnt == 2'(BEATS - 1));

    always_comb begin
        next = state;
        case (state)
            BS_IDLE: begin
                // read command taken when ready
                if (line.read && i_bmem_ready) begin
                    next = BS_READ_WAIT;
                end else if (line.write) begin
                    next = BS_WRITE_BEATS;
                end
            end
            BS_READ_WAIT: if (i_bmem_rvalid && last) next = BS_IDLE;
            BS_WRITE_BEATS: if (i_bmem_ready && last) next = BS_IDLE;
            default: next = BS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= BS_IDLE;
            cnt <= '0;
        end else begin
            state <= next;
            // wraps to zero after the fourth beat
            if ((state == BS_READ_WAIT && i_bmem_rvalid) ||
                (state == BS_WRITE_BEATS && i_bmem_ready)) begin
                cnt <= cnt + 2'd1;
            end
        end
    end

    // lowest beat arrives first, shift down
    always_ff @(posedge clk) begin
        if (state == BS_READ_WAIT && i_bmem_rvalid) begin
            rbuf <= {i_bmem_rdata, rbuf[LINE_BITS-$bits(beat_t)-1:$bits(beat_t)]};
        end
    end

    // outputs follow state, so they hold while ready is low
    assign o_bmem_read = (state == BS_IDLE) && line.read;
    assign o_bmem_write = (state == BS_WRITE_BEATS);
    assign o_bmem_addr = line.addr;
    assign o_bmem_wdata = line.wdata[{cnt, 6'd0} +: $bits(beat_t)];

    assign line.rdata = {i_bmem_rdata, rbuf};
    assign line.resp = (state == BS_READ_WAIT && i_bmem_rvalid && last) ||
                       (state == BS_WRITE_BEATS && i_bmem_ready && last);

endmodule

// File: hw/cache_pkg.sv
package cache_pkg;

    // line geometry
    localparam int LINE_BITS = 256;
    localparam int BEATS = 4;
    localparam int SETS = 8;

    // address split: tag | index | offset
    localparam int OFFSET_BITS = 5;
    localparam int INDEX_BITS = 3;
    localparam int TAG_BITS = 24;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] mask_t;
    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [63:0] beat_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;

    // data cache controller
    typedef enum logic [2:0] {
        DC_IDLE, DC_COMPARE, DC_WRITE_BACK, DC_ALLOCATE, DC_RESPOND
    } dcache_state_t;

    // bmem burst adapter
    typedef enum logic [1:0] {BS_IDLE, BS_READ_WAIT, BS_WRITE_BEATS} burst_state_t;

endpackage

// File: hw/cache_unit.sv
module cache_unit (
    input  logic             clk,
    input  logic             rst,
    input  cache_pkg::addr_t i_imem_addr,
    input  cache_pkg::mask_t i_imem_rmask,
    output cache_pkg::word_t o_imem_rdata,
    output logic             o_imem_resp,
    input  cache_pkg::addr_t i_dmem_addr,
    input  cache_pkg::mask_t i_dmem_rmask,
    input  cache_pkg::mask_t i_dmem_wmask,
    input  cache_pkg::word_t i_dmem_wdata,
    output cache_pkg::word_t o_dmem_rdata,
    output logic             o_dmem_resp,
    output cache_pkg::addr_t o_bmem_addr,
    output logic             o_bmem_read,
    output logic             o_bmem_write,
    output cache_pkg::beat_t o_bmem_wdata,
    input  logic             i_bmem_ready,
    input  cache_pkg::beat_t i_bmem_rdata,
    input  logic             i_bmem_rvalid
);
    import cache_pkg::*;

    line_if i_line ();
    line_if d_line ();
    line_if b_line ();

    // data request latch
    addr_t d_addr_q;
    mask_t d_rmask_q;
    mask_t d_wmask_q;
    word_t d_wdata_q;
    logic d_strobe;

    // what the data cache sees
    addr_t d_addr;
    mask_t d_rmask;
    mask_t d_wmask;
    word_t d_wdata;
    word_t dc_rdata;
    logic dc_resp;

    assign d_strobe = |(i_dmem_rmask | i_dmem_wmask);

    always_ff @(posedge clk) begin
        if (rst) begin
            d_rmask_q <= '0;
            d_wmask_q <= '0;
        end else if (d_strobe) begin
            d_rmask_q <= i_dmem_rmask;
            d_wmask_q <= i_dmem_wmask;
        end else if (dc_resp) begin
            d_rmask_q <= '0;
            d_wmask_q <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (d_strobe) begin
            d_addr_q <= i_dmem_addr;
            d_wdata_q <= i_dmem_wdata;
        end
    end

    // live request in the strobe cycle, latched copy after
    assign d_addr = d_strobe ? i_dmem_addr : d_addr_q;
    assign d_rmask = d_strobe ? i_dmem_rmask : d_rmask_q;
    assign d_wmask = d_strobe ? i_dmem_wmask : d_wmask_q;
    assign d_wdata = d_strobe ? i_dmem_wdata : d_wdata_q;

    // registered data response
    always_ff @(posedge clk) begin
        if (rst) begin
            o_dmem_resp <= 1'b0;
        end else begin
            o_dmem_resp <= dc_resp;
        end
    end

    always_ff @(posedge clk) begin
        o_dmem_rdata <= dc_rdata;
    end

    icache icache_i (
        .clk     (clk),
        .rst     (rst),
        .i_addr  (i_imem_addr),
        .i_rmask (i_imem_rmask),
        .o_rdata (o_imem_rdata),
        .o_resp  (o_imem_resp),
        .mem     (i_line)
    );

    dcache dcache_i (
        .clk     (clk),
        .rst     (rst),
        .i_addr  (d_addr),
        .i_rmask (d_rmask),
        .i_wmask (d_wmask),
        .i_wdata (d_wdata),
        .o_rdata (dc_rdata),
        .o_resp  (dc_resp),
        .mem     (d_line)
    );

    line_arbiter arb_i (
        .clk    (clk),
        .rst    (rst),
        .i_side (i_line),
        .d_side (d_line),
        .mem    (b_line)
    );

    bmem_burst burst_i (
        .clk           (clk),
        .rst           (rst),
        .line          (b_line),
        .o_bmem_addr   (o_bmem_addr),
        .o_bmem_read   (o_bmem_read),
        .o_bmem_write  (o_bmem_write),
        .o_bmem_wdata  (o_bmem_wdata),
        .i_bmem_ready  (i_bmem_ready),
        .i_bmem_rdata  (i_bmem_rdata),
        .i_bmem_rvalid (i_bmem_rvalid)
    );

endmodule

// File: hw/dcache.sv
module dcache (
    input  logic             clk,
    input  logic             rst,
    input  cache_pkg::addr_t i_addr,
    input  cache_pkg::mask_t i_rmask,
    input  cache_pkg::mask_t i_wmask,
    input  cache_pkg::word_t i_wdata,
    output cache_pkg::word_t o_rdata,
    output logic             o_resp,
    line_if.requester        mem
);
    import cache_pkg::*;

    tag_t tags [SETS];
    line_t lines [SETS];
    logic [SETS-1:0] valid;
    logic [SETS-1:0] dirty;

    dcache_state_t state;
    dcache_state_t next;

    tag_t tag;
    index_t idx;
    logic [OFFSET_BITS-3:0] word_sel;
    logic hit;
    logic is_write;
    line_t merged;

    assign tag = i_addr[31 -: TAG_BITS];
    assign idx = i_addr[OFFSET_BITS +: INDEX_BITS];
    assign word_sel = i_addr[OFFSET_BITS-1:2];
    assign hit = valid[idx] && (tags[idx] == tag);
    assign is_write = |i_wmask;

    // access happens on a compare hit or right after a refill
    assign o_resp = (state == DC_COMPARE && hit) || (state == DC_RESPOND);
    assign o_rdata = lines[idx][{word_sel, 5'd0} +: 32];

    // store data merged into the current line
    always_comb begin
        merged = lines[idx];
        for (int b = 0; b < 4; b++) begin
            if (i_wmask[b]) begin
                merged[{word_sel, 5'd0} + 8*b +: 8] = i_wdata[8*b +: 8];
            end
        end
    end

    // victim goes back to the address of its stored tag
    assign mem.write = (state == DC_WRITE_BACK);
    assign mem.read = (state == DC_ALLOCATE);
    assign mem.addr = mem.write ? {tags[idx], idx, {OFFSET_BITS{1'b0}}}
                                : {tag, idx, {OFFSET_BITS{1'b0}}};
    assign mem.wdata = lines[idx];

    always_comb begin
        next = state;
        case (state)
            DC_IDLE: begin
                if (|(i_rmask | i_wmask)) begin
                    next = DC_COMPARE;
                end
            end
            DC_COMPARE: begin
                if (hit) begin
                    next = DC_IDLE;
                end else if (valid[idx] && dirty[idx]) begin
                    next = DC_WRITE_BACK;
                end else begin
                    next = DC_ALLOCATE;
                end
            end
            // write-back done, fill the new line
            DC_WRITE_BACK: if (mem.resp) next = DC_ALLOCATE;
            DC_ALLOCATE: if (mem.resp) next = DC_RESPOND;
            DC_RESPOND: next = DC_IDLE;
            default: next = DC_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= DC_IDLE;
            valid <= '0;
            dirty <= '0;
        end else begin
            state <= next;
            if (state == DC_ALLOCATE && mem.resp) begin
                valid[idx] <= 1'b1;
                dirty[idx] <= 1'b0;
            end else if (o_resp && is_write) begin
                dirty[idx] <= 1'b1;
            end
        end
    end

    // line and tag arrays
    always_ff @(posedge clk) begin
        if (state == DC_ALLOCATE && mem.resp) begin
            lines[idx] <= mem.rdata;
            tags[idx] <= tag;
        end else if (o_resp && is_write) begin
            lines[idx] <= merged;
        end
    end

endmodule

// File: hw/icache.sv
module icache (
    input  logic             clk,
    input  logic             rst,
    input  cache_pkg::addr_t i_addr,
    input  cache_pkg::mask_t i_rmask,
    output cache_pkg::word_t o_rdata,
    output logic             o_resp,
    line_if.requester        mem
);
    import cache_pkg::*;

    tag_t tags [SETS];
    line_t lines [SETS];
    logic [SETS-1:0] valid;

    // set between strobe and resp
    logic pending;

    tag_t tag;
    index_t idx;
    logic [OFFSET_BITS-3:0] word_sel;
    logic hit;

    // address held steady by fetch until resp
    assign tag = i_addr[31 -: TAG_BITS];
    assign idx = i_addr[OFFSET_BITS +: INDEX_BITS];
    assign word_sel = i_addr[OFFSET_BITS-1:2];
    assign hit = valid[idx] && (tags[idx] == tag);

    // answer one cycle after strobe on a hit
    assign o_resp = pending && hit;
    assign o_rdata = lines[idx][{word_sel, 5'd0} +: 32];

    // on a miss ask for the whole line
    assign mem.read = pending && !hit;
    assign mem.write = 1'b0;
    assign mem.addr = {tag, idx, {OFFSET_BITS{1'b0}}};
    assign mem.wdata = '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (|i_rmask) begin
            pending <= 1'b1;
        end else if (o_resp) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (mem.resp) begin
            valid[idx] <= 1'b1;
        end
    end

    // refill so the hit path answers next cycle
    always_ff @(posedge clk) begin
        if (mem.resp) begin
            lines[idx] <= mem.rdata;
            tags[idx] <= tag;
        end
    end

endmodule

// File: hw/line_arbiter.sv
module line_arbiter (
    input  logic      clk,
    input  logic      rst,
    line_if.server    i_side,
    line_if.server    d_side,
    line_if.requester mem
);

    // grant held until the served resp
    logic busy;
    // 0 for the instruction side, 1 for data
    logic owner_d;

    logic i_req;
    logic d_req;

    assign i_req = i_side.read || i_side.write;
    assign d_req = d_side.read || d_side.write;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            owner_d <= 1'b0;
        end else if (!busy) begin
            // instruction side wins a tie
            if (i_req) begin
                busy <= 1'b1;
                owner_d <= 1'b0;
            end else if (d_req) begin
                busy <= 1'b1;
                owner_d <= 1'b1;
            end
        end else if (mem.resp) begin
            busy <= 1'b0;
        end
    end

    // owner's command, only while granted
    assign mem.read = busy && (owner_d ? d_side.read : i_side.read);
    assign mem.write = busy && (owner_d ? d_side.write : i_side.write);
    assign mem.addr = owner_d ? d_side.addr : i_side.addr;
    assign mem.wdata = owner_d ? d_side.wdata : i_side.wdata;

    // resp goes back the same cycle, owner only
    assign i_side.resp = busy && !owner_d && mem.resp;
    assign d_side.resp = busy && owner_d && mem.resp;
    assign i_side.rdata = owner_d ? '0 : mem.rdata;
    assign d_side.rdata = owner_d ? mem.rdata : '0;

endmodule

// File: hw/line_if.sv
interface line_if;
    import cache_pkg::*;

    // line-aligned address
    addr_t addr;
    logic read;
    logic write;
    line_t wdata;
    line_t rdata;
    // one-cycle pulse, rdata valid with it
    logic resp;

    modport requester (
        output addr, read, write, wdata,
        input rdata, resp
    );

    modport server (
        input addr, read, write, wdata,
        output rdata, resp
    );

endinterface

// File: test/cache_unit_props.sv
module cache_unit_props (
    input logic                      clk,
    input logic                      rst,
    input logic                      i_bmem_read,
    input logic                      i_bmem_write,
    input cache_pkg::addr_t          i_bmem_addr,
    input logic                      i_dmem_resp,
    input logic                      i_bmem_ready,
    input logic                      i_arb_busy,
    input cache_pkg::dcache_state_t  i_dc_state
);
    import cache_pkg::*;

    // count of failed assertions
    int fail_count = 0;
    // busy data cache cycles with bmem ready
    int ready_cycles;

    always @(posedge clk) begin
        if (rst || i_dc_state == DC_IDLE) begin
            ready_cycles <= 0;
        end else if (i_bmem_ready) begin
            ready_cycles <= ready_cycles + 1;
        end
    end

    // a write burst keeps one line address
    assert property (@(posedge clk) disable iff (rst)
        (i_bmem_write && $past(i_bmem_write)) |-> $stable(i_bmem_addr))
        else begin
            $error("bmem address changed inside a write burst");
            fail_count++;
        end

    // data response lasts one cycle
    assert property (@(posedge clk) disable iff (rst) i_dmem_resp |=> !i_dmem_resp)
        else begin
            $error("o_dmem_resp longer than one cycle");
            fail_count++;
        end

    // bmem commands only under an arbiter grant
    assert property (@(posedge clk) disable iff (rst) (i_bmem_read || i_bmem_write) |-> i_arb_busy)
        else begin
            $error("bmem command without a grant");
            fail_count++;
        end

    // writeback plus refill fits well inside this bound
    assert property (@(posedge clk) disable iff (rst) ready_cycles < 200)
        else begin
            $error("data cache stuck outside IDLE");
            fail_count++;
        end

endmodule

bind cache_unit cache_unit_props props_i (
    .clk          (clk),
    .rst          (rst),
    .i_bmem_read  (o_bmem_read),
    .i_bmem_write (o_bmem_write),
    .i_bmem_addr  (o_bmem_addr),
    .i_dmem_resp  (o_dmem_resp),
    .i_bmem_ready (i_bmem_ready),
    .i_arb_busy   (arb_i.busy),
    .i_dc_state   (dcache_i.state)
);

// File: test/tb_cache_unit.sv
module tb_cache_unit;
    import cache_pkg::*;

    logic clk;
    logic rst;
    addr_t i_imem_addr;
    mask_t i_imem_rmask;
    word_t o_imem_rdata;
    logic o_imem_resp;
    addr_t i_dmem_addr;
    mask_t i_dmem_rmask;
    mask_t i_dmem_wmask;
    word_t i_dmem_wdata;
    word_t o_dmem_rdata;
    logic o_dmem_resp;
    addr_t o_bmem_addr;
    logic o_bmem_read;
    logic o_bmem_write;
    beat_t o_bmem_wdata;
    logic i_bmem_ready = 1'b0;
    beat_t i_bmem_rdata = '0;
    logic i_bmem_rvalid = 1'b0;

    // bmem beats that were written back
    beat_t bmem [addr_t];
    // reference model of the stored bytes
    logic [7:0] ref_mem [addr_t];

    // responder read and write progress
    logic rd_busy = 1'b0;
    addr_t rd_addr;
    int rd_cnt;
    int wr_cnt = 0;

    cache_unit cache_unit_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // initial memory image depends on every address bit
    function automatic beat_t init_beat(addr_t a);
        return {a ^ 32'h5a5a_a5a5, (a * 32'h9e37_79b1) ^ 32'h0f0f_0f0f};
    endfunction

    function automatic beat_t mem_beat(addr_t a);
        return bmem.exists(a) ? bmem[a] : init_beat(a);
    endfunction

    function automatic logic [7:0] ref_byte(addr_t a);
        beat_t b;
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        b = init_beat({a[31:3], 3'b000});
        return b[8 * a[2:0] +: 8];
    endfunction

    // little endian word from the model
    function automatic word_t ref_word(addr_t a);
        return {ref_byte(a + 3), ref_byte(a + 2), ref_byte(a + 1), ref_byte(a)};
    endfunction

    function automatic void store_model(addr_t a, mask_t m, word_t w);
        for (int b = 0; b < 4; b++) begin
            if (m[b]) begin
                ref_mem[a + b] = w[8 * b +: 8];
            end
        end
    endfunction

    task automatic check(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic timeout_fail(string what);
        $display("the %s never came", what);
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    endtask

    // cyc counts cycles from the strobe cycle to the resp cycle
    task automatic ifetch(addr_t a, output word_t data, output int cyc);
        i_imem_addr <= a;
        i_imem_rmask <= 4'hf;
        cyc = 0;
        @(posedge clk);
        i_imem_rmask <= '0;
        while (!o_imem_resp) begin
            cyc++;
            if (cyc > 1000) begin
                timeout_fail("instruction response");
            end
            @(posedge clk);
        end
        data = o_imem_rdata;
    endtask

    task automatic daccess(addr_t a, mask_t rm, mask_t wm, word_t w, output word_t data,
                           output int cyc);
        i_dmem_addr <= a;
        i_dmem_rmask <= rm;
        i_dmem_wmask <= wm;
        i_dmem_wdata <= w;
        cyc = 0;
        @(posedge clk);
        i_dmem_rmask <= '0;
        i_dmem_wmask <= '0;
        while (!o_dmem_resp) begin
            cyc++;
            if (cyc > 1000) begin
                timeout_fail("data response");
            end
            @(posedge clk);
        end
        data = o_dmem_rdata;
    endtask

    // stop at the first failed property
    always @(negedge clk) begin
        if (cache_unit_i.props_i.fail_count != 0) begin
            $display("a bound assertion failed");
            $display("TESTS FAILED");
            $fatal(1, "assertion failure");
        end
    end

    // bmem responder
    always @(posedge clk) begin
        if (rst) begin
            i_bmem_ready <= 1'b0;
            i_bmem_rvalid <= 1'b0;
            rd_busy = 1'b0;
            wr_cnt = 0;
        end else begin
            // ready about three cycles in four
            i_bmem_ready <= ($urandom_range(0, 3) != 0);
            if (o_bmem_write && i_bmem_ready) begin
                bmem[o_bmem_addr + 8 * wr_cnt] = o_bmem_wdata;
                wr_cnt = (wr_cnt + 1) % BEATS;
            end
            if (o_bmem_read && i_bmem_ready) begin
                // nothing may be in flight here
                check("bmem read overlap", {rd_busy, wr_cnt != 0}, 0);
                rd_busy = 1'b1;
                rd_addr = o_bmem_addr;
                rd_cnt = 0;
            end
            // beats back lowest first with random gaps
            if (rd_busy && $urandom_range(0, 2) != 0) begin
                i_bmem_rvalid <= 1'b1;
                i_bmem_rdata <= mem_beat(rd_addr + 8 * rd_cnt);
                rd_cnt++;
                rd_busy = (rd_cnt < BEATS);
            end else begin
                i_bmem_rvalid <= 1'b0;
            end
        end
    end

    initial begin
        word_t data;
        word_t idata;
        int cyc;
        int icyc;
        addr_t a;
        mask_t m;
        word_t w;
        int s;
        beat_t bt;
        void'($urandom(32'heb0e));
        rst = 1'b1;
        i_imem_addr = '0;
        i_imem_rmask = '0;
        i_dmem_addr = '0;
        i_dmem_rmask = '0;
        i_dmem_wmask = '0;
        i_dmem_wdata = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        // quiet until the first request
        repeat (3) begin
            @(posedge clk);
            check("o_imem_resp", o_imem_resp, 0);
            check("o_dmem_resp", o_dmem_resp, 0);
            check("o_bmem_read", o_bmem_read, 0);
            check("o_bmem_write", o_bmem_write, 0);
        end
        // fetch pairs over 32 lines in 8 sets
        // the repeat must hit
        repeat (40) begin
            a = 32'h0000_1000 + ($urandom_range(0, 255) << 2);
            ifetch(a, data, cyc);
            check("o_imem_rdata", data, ref_word(a));
            ifetch(a, data, cyc);
            check("o_imem_rdata", data, ref_word(a));
            check("imem hit latency", cyc, 1);
        end
        // tag bits 9:8 give four tags per set
        repeat (150) begin
            a = 32'h8000_0000 | ($urandom_range(0, 255) << 2);
            if ($urandom_range(0, 1) != 0) begin
                m = $urandom_range(1, 15);
                w = $urandom();
                daccess(a, '0, m, w, data, cyc);
                store_model(a, m, w);
            end
            daccess(a, 4'hf, '0, '0, data, cyc);
            check("o_dmem_rdata", data, ref_word(a));
            daccess(a, 4'hf, '0, '0, data, cyc);
            check("o_dmem_rdata", data, ref_word(a));
            check("dmem hit latency", cyc, 2);
        end
        // each store to this set evicts the previous dirty line
        s = $urandom_range(0, 7);
        for (int t = 0; t < 4; t++) begin
            a = 32'h8000_0000 | (t << 8) | (s << 5) | (t << 2);
            w = $urandom();
            daccess(a, '0, 4'hf, w, data, cyc);
            store_model(a, 4'hf, w);
        end
        for (int t = 0; t < 4; t++) begin
            a = 32'h8000_0000 | (t << 8) | (s << 5) | (t << 2);
            daccess(a, 4'hf, '0, '0, data, cyc);
            check("o_dmem_rdata", data, ref_word(a));
        end
        // both ports miss together
        // data side pushes every set out
        for (int i = 0; i < SETS; i++) begin
            fork
                ifetch(32'h0000_4000 + i * 32 + 4, idata, icyc);
                daccess(32'h8000_1000 + i * 32, 4'hf, '0, '0, data, cyc);
            join
            check("o_imem_rdata", idata, ref_word(32'h0000_4000 + i * 32 + 4));
            check("o_dmem_rdata", data, ref_word(32'h8000_1000 + i * 32));
        end
        // bmem must hold every stored byte by now
        foreach (ref_mem[b]) begin
            bt = mem_beat({b[31:3], 3'b000});
            check("bmem byte", bt[8 * b[2:0] +: 8], ref_mem[b]);
        end
        if (cache_unit_i.props_i.fail_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("TESTS FAILED");
            $fatal(1, "assertion failure");
        end
    end

endmodule
